//--- verification/soc_bus_testdata.txt
# op addr data: W write, R read and compare, Q wait irq, N irq low, L leds
# addr and data are hex, unused fields are zero
N 0000 00
L 0000 00
W 0000 A5
W 03FF 5A
W 0123 3C
W 0200 C3
R 0000 A5
R 03FF 5A
R 0123 3C
R 0200 C3
R 0400 FF
W FF00 96
L 0000 96
R FF00 96
W FE00 01
R FE00 01
R FE00 B8
R FE00 5C
R FE00 2E
R FE00 17
R FE00 B3
R FE00 E1
R FE00 C8
W FE00 00
R FE00 01
R FE00 B8
W FD00 20
W FD01 00
R FD00 20
R FD01 00
W FD02 01
Q 0000 00
R FD03 01
W FD03 01
N 0000 00
W FD02 00
W FD03 01
N 0000 00
R 8000 FF
W 8000 00
R 0000 A5
R FF00 96
L 0000 96

//--- filelist.f
+incdir+source
source/soc_pkg.sv
source/wb8_if.sv
source/reset_sequencer.sv
source/bus_decoder.sv
source/interval_timer.sv
source/lfsr_prng.sv
source/ram_block.sv
source/led_port.sv
source/soc_bus_top.sv
verification/soc_bus_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the bus testbench from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module soc_bus_tb -o soc_bus_sim \
    && ./obj_dir/soc_bus_sim \
    || { echo "simulation failed"; exit 1; }

//--- verification/soc_bus_tb.sv
`include "soc_settings.svh"

module soc_bus_tb;

    localparam int ack_latency   = 3;
    localparam int ack_timeout   = 20;
    localparam int ready_timeout = 100;
    localparam int irq_timeout   = 1000;

    logic                      clk = 1'b0;
    logic                      rst_i;
    logic                      bus_stb_i;
    logic                      bus_we_i;
    logic [`SOC_ADDR_BITS-1:0] bus_adr_i;
    logic [`SOC_DATA_BITS-1:0] bus_dat_i;
    logic [`SOC_DATA_BITS-1:0] bus_dat_o;
    logic                      bus_ack_o;
    logic                      irq_o;
    logic [7:0]                leds_o;
    logic                      ready_o;

    soc_bus_top DUT (
        .clk       (clk),
        .rst_i     (rst_i),
        .bus_stb_i (bus_stb_i),
        .bus_we_i  (bus_we_i),
        .bus_adr_i (bus_adr_i),
        .bus_dat_i (bus_dat_i),
        .bus_dat_o (bus_dat_o),
        .bus_ack_o (bus_ack_o),
        .irq_o     (irq_o),
        .leds_o    (leds_o),
        .ready_o   (ready_o)
    );

    always #5 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            report_failure($sformatf("Fail %s expected %0h actual %0h", name, exp, act));
        end
    endtask

    // called and returns one time unit after a rising edge
    task automatic bus_access(input string name, input logic we,
                              input logic [15:0] adr, input logic [7:0] wdat,
                              output logic [7:0] rdat);
        int cycles;
        bus_stb_i = 1'b1;
        bus_we_i  = we;
        bus_adr_i = adr;
        bus_dat_i = wdat;
        cycles    = 0;
        while (bus_ack_o !== 1'b1) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > ack_timeout) begin
                report_failure($sformatf("%s got no bus acknowledge", name));
            end
        end
        rdat      = bus_dat_o;
        bus_stb_i = 1'b0;
        bus_we_i  = 1'b0;
        // first counted edge is the one that samples stb
        check_value({name, " latency"}, ack_latency, cycles - 1);
        // stb stays low for one cycle between accesses
        @(posedge clk);
        #1;
    endtask

    task automatic wait_for_irq(input string name);
        int cycles;
        cycles = 0;
        while (irq_o !== 1'b1) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > irq_timeout) begin
                report_failure($sformatf("%s saw no timer interrupt in time", name));
            end
        end
    endtask

    initial begin
        int         fd;
        int         code;
        int         line_no;
        int         waited;
        string      line;
        string      name;
        logic [7:0]  op;
        logic [15:0] adr;
        logic [7:0]  dat;
        logic [7:0]  rdat;
        rst_i     = 1'b1;
        bus_stb_i = 1'b0;
        bus_we_i  = 1'b0;
        bus_adr_i = '0;
        bus_dat_i = '0;
        repeat (10) @(posedge clk);
        #1;
        check_value("ready during reset", 0, ready_o);
        rst_i  = 1'b0;
        waited = 0;
        while (ready_o !== 1'b1) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > ready_timeout) begin
                report_failure("ready_o never rose after reset");
            end
        end
        assert (waited >= `RESET_HOLD_CYCLES) else begin
            report_failure("ready_o rose before the reset hold ended");
        end
        check_value("ack after reset", 0, bus_ack_o);
        fd = $fopen("verification/soc_bus_testdata.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open verification/soc_bus_testdata.txt");
        end
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            code = $sscanf(line, "%c %h %h", op, adr, dat);
            if (code != 3) begin
                report_failure($sformatf("data line %0d is malformed", line_no));
            end
            name = $sformatf("%c line %0d adr %h", op, line_no, adr);
            case (op)
                "W": bus_access(name, 1'b1, adr, dat, rdat);
                "R": begin
                    bus_access(name, 1'b0, adr, 8'h00, rdat);
                    check_value(name, dat, rdat);
                end
                "Q": wait_for_irq(name);
                "N": check_value(name, 0, irq_o);
                "L": check_value(name, dat, leds_o);
                default: report_failure($sformatf("unknown operation on line %0d", line_no));
            endcase
        end
        $fclose(fd);
        $display("** PASS **");
        $finish;
    end

endmodule

//--- source/soc_bus_top.sv
`include "soc_settings.svh"

module soc_bus_top (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      bus_stb_i,
    input  logic                      bus_we_i,
    input  logic [`SOC_ADDR_BITS-1:0] bus_adr_i,
    input  logic [`SOC_DATA_BITS-1:0] bus_dat_i,
    output logic [`SOC_DATA_BITS-1:0] bus_dat_o,
    output logic                      bus_ack_o,
    output logic                      irq_o,
    output logic [7:0]                leds_o,
    output logic                      ready_o
);

    logic sys_rst;

    wb8_if ram_bus ();
    wb8_if timer_bus ();
    wb8_if prng_bus ();
    wb8_if led_bus ();

    reset_sequencer u_reset_sequencer (
        .clk       (clk),
        .rst_i     (rst_i),
        .sys_rst_o (sys_rst)
    );

    assign ready_o = ~sys_rst;

    bus_decoder u_bus_decoder (
        .clk       (clk),
        .rst_i     (sys_rst),
        .stb_i     (bus_stb_i),
        .we_i      (bus_we_i),
        .adr_i     (bus_adr_i),
        .dat_i     (bus_dat_i),
        .dat_o     (bus_dat_o),
        .ack_o     (bus_ack_o),
        .ram_bus   (ram_bus.master),
        .timer_bus (timer_bus.master),
        .prng_bus  (prng_bus.master),
        .led_bus   (led_bus.master)
    );

    ram_block u_ram_block (
        .clk (clk),
        .bus (ram_bus.slave)
    );

    interval_timer u_interval_timer (
        .clk   (clk),
        .rst_i (sys_rst),
        .bus   (timer_bus.slave),
        .irq_o (irq_o)
    );

    lfsr_prng u_lfsr_prng (
        .clk   (clk),
        .rst_i (sys_rst),
        .bus   (prng_bus.slave)
    );

    led_port u_led_port (
        .clk    (clk),
        .rst_i  (sys_rst),
        .bus    (led_bus.slave),
        .leds_o (leds_o)
    );

endmodule

//--- source/led_port.sv
module led_port (
    input  logic       clk,
    input  logic       rst_i,
    wb8_if.slave       bus,
    output logic [7:0] leds_o
);

    logic access;

    assign access = bus.stb && !bus.ack;

    // whole page mirrors the one register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            leds_o  <= 8'h00;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;
            if (access && bus.we) begin
                leds_o <= bus.dat_w;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            bus.dat_r <= leds_o;
        end
    end

endmodule

//--- source/ram_block.sv
`include "soc_settings.svh"

module ram_block (
    input  logic clk,
    wb8_if.slave bus
);

    localparam int depth = 1 << `RAM_ADDR_BITS;

    logic [7:0] mem [0:depth-1];
    logic       access;

    logic [`RAM_ADDR_BITS-1:0] word_adr;

    assign access   = bus.stb && !bus.ack;
    assign word_adr = bus.adr[`RAM_ADDR_BITS-1:0];

    // one-cycle ack for every strobe
    always_ff @(posedge clk) begin
        bus.ack <= access;
    end

    always_ff @(posedge clk) begin
        if (access && bus.we) begin
            mem[word_adr] <= bus.dat_w;
        end
        if (access) begin
            bus.dat_r <= mem[word_adr];
        end
    end

endmodule

//--- source/lfsr_prng.sv
module lfsr_prng (
    input  logic clk,
    input  logic rst_i,
    wb8_if.slave bus
);

    // x^8 + x^6 + x^5 + x^4 + 1, right-shifting Galois form
    localparam logic [7:0] taps = 8'hB8;

    logic [7:0] lfsr_q;
    logic [7:0] lfsr_next;
    logic       access;
    logic       rd_data;

    assign access    = bus.stb && !bus.ack;
    assign rd_data   = access && !bus.we && (bus.adr[7:0] == 8'd0);
    assign lfsr_next = {1'b0, lfsr_q[7:1]} ^ (lfsr_q[0] ? taps : 8'h00);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            lfsr_q  <= 8'h01;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;
            if (access && bus.we) begin
                // all-zero state would lock up
                lfsr_q <= (bus.dat_w == 8'h00) ? 8'h01 : bus.dat_w;
            end else if (rd_data) begin
                lfsr_q <= lfsr_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            bus.dat_r <= rd_data ? lfsr_q : 8'h00;
        end
    end

endmodule

//--- source/interval_timer.sv
module interval_timer (
    input  logic  clk,
    input  logic  rst_i,
    wb8_if.slave  bus,
    output logic  irq_o
);

    logic [15:0] reload;
    logic [15:0] count;
    logic        enable;
    logic        flag;
    logic        access;
    logic [7:0]  offset;

    assign access = bus.stb && !bus.ack;
    assign offset = bus.adr[7:0];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            reload  <= '0;
            count   <= '0;
            enable  <= 1'b0;
            flag    <= 1'b0;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;
            if (access && bus.we) begin
                case (offset)
                    8'd0: reload[7:0]  <= bus.dat_w;
                    8'd1: reload[15:8] <= bus.dat_w;
                    8'd2: enable       <= bus.dat_w[0];
                    8'd3: begin
                        if (bus.dat_w[0]) begin
                            flag <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
            // a new expiry wins over a clear in the same cycle
            if (enable) begin
                if (count == '0) begin
                    count <= reload;
                    flag  <= 1'b1;
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (offset)
                8'd0:    bus.dat_r <= reload[7:0];
                8'd1:    bus.dat_r <= reload[15:8];
                8'd2:    bus.dat_r <= {7'd0, enable};
                8'd3:    bus.dat_r <= {7'd0, flag};
                8'd4:    bus.dat_r <= count[7:0];
                8'd5:    bus.dat_r <= count[15:8];
                default: bus.dat_r <= 8'h00;
            endcase
        end
    end

    assign irq_o = flag;

endmodule

//--- source/bus_decoder.sv
`include "soc_settings.svh"

module bus_decoder (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      stb_i,
    input  logic                      we_i,
    input  logic [`SOC_ADDR_BITS-1:0] adr_i,
    input  logic [`SOC_DATA_BITS-1:0] dat_i,
    output logic [`SOC_DATA_BITS-1:0] dat_o,
    output logic                      ack_o,
    wb8_if.master                     ram_bus,
    wb8_if.master                     timer_bus,
    wb8_if.master                     prng_bus,
    wb8_if.master                     led_bus
);

    import soc_pkg::*;

    localparam logic [`SOC_ADDR_BITS-1:0] page_mask = 16'hFF00;
    localparam logic [`SOC_ADDR_BITS-1:0] ram_mask  = (1 << `RAM_ADDR_BITS) - 1;

    bus_state_e  state;
    periph_sel_e sel_q;
    logic        stb_q;
    logic        none_ack;
    logic        start;
    logic        slave_ack;

    logic [`SOC_ADDR_BITS-1:0] adr_q;
    logic [`SOC_DATA_BITS-1:0] dat_q;
    logic [`SOC_DATA_BITS-1:0] slave_dat;
    logic                      we_q;

    function automatic periph_sel_e decode_sel(input logic [`SOC_ADDR_BITS-1:0] adr);
        if ((adr & ~ram_mask) == '0) begin
            return sel_ram;
        end else if ((adr & page_mask) == `TIMER_BASE) begin
            return sel_timer;
        end else if ((adr & page_mask) == `PRNG_BASE) begin
            return sel_prng;
        end else if ((adr & page_mask) == `LED_BASE) begin
            return sel_led;
        end
        return sel_none;
    endfunction

    // stb is still high in the cycle that sees ack, so skip that one
    assign start = (state == st_idle) && stb_i && !ack_o;

    always_comb begin
        case (sel_q)
            sel_ram: begin
                slave_ack = ram_bus.ack;
                slave_dat = ram_bus.dat_r;
            end
            sel_timer: begin
                slave_ack = timer_bus.ack;
                slave_dat = timer_bus.dat_r;
            end
            sel_prng: begin
                slave_ack = prng_bus.ack;
                slave_dat = prng_bus.dat_r;
            end
            sel_led: begin
                slave_ack = led_bus.ack;
                slave_dat = led_bus.dat_r;
            end
            default: begin
                slave_ack = none_ack;
                slave_dat = `UNMAPPED_DATA;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state    <= st_idle;
            sel_q    <= sel_none;
            stb_q    <= 1'b0;
            none_ack <= 1'b0;
            ack_o    <= 1'b0;
        end else begin
            ack_o    <= 1'b0;
            // stand-in slave so unmapped accesses keep the same latency
            none_ack <= stb_q && (sel_q == sel_none);
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_access;
                    end
                end
                st_access: begin
                    sel_q <= decode_sel(adr_q);
                    stb_q <= 1'b1;
                    state <= st_respond;
                end
                st_respond: begin
                    stb_q <= 1'b0;
                    if (slave_ack) begin
                        ack_o <= 1'b1;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= adr_i;
            we_q  <= we_i;
            dat_q <= dat_i;
        end
        if ((state == st_respond) && slave_ack) begin
            dat_o <= slave_dat;
        end
    end

    assign ram_bus.stb   = stb_q && (sel_q == sel_ram);
    assign timer_bus.stb = stb_q && (sel_q == sel_timer);
    assign prng_bus.stb  = stb_q && (sel_q == sel_prng);
    assign led_bus.stb   = stb_q && (sel_q == sel_led);

    // slaves only see their offset within the page
    assign ram_bus.adr   = adr_q & ram_mask;
    assign timer_bus.adr = adr_q & ~page_mask;
    assign prng_bus.adr  = adr_q & ~page_mask;
    assign led_bus.adr   = adr_q & ~page_mask;

    assign ram_bus.we    = we_q;
    assign timer_bus.we  = we_q;
    assign prng_bus.we   = we_q;
    assign led_bus.we    = we_q;

    assign ram_bus.dat_w   = dat_q;
    assign timer_bus.dat_w = dat_q;
    assign prng_bus.dat_w  = dat_q;
    assign led_bus.dat_w   = dat_q;

endmodule

//--- source/reset_sequencer.sv
`include "soc_settings.svh"

module reset_sequencer (
    input  logic clk,
    input  logic rst_i,
    output logic sys_rst_o
);

    localparam int hold    = `RESET_HOLD_CYCLES;
    localparam int count_w = $clog2(hold + 1);

    logic [count_w-1:0] count;

    // rst_i restarts the hold at any time
    always_ff @(posedge clk) begin
        if (rst_i) begin
            count     <= '0;
            sys_rst_o <= 1'b1;
        end else if (count != count_w'(hold)) begin
            count     <= count + 1'b1;
            sys_rst_o <= 1'b1;
        end else begin
            sys_rst_o <= 1'b0;
        end
    end

endmodule

//--- source/wb8_if.sv
`include "soc_settings.svh"

interface wb8_if;

    logic                      stb;
    logic                      we;
    logic [`SOC_ADDR_BITS-1:0] adr;
    logic [`SOC_DATA_BITS-1:0] dat_w;
    logic [`SOC_DATA_BITS-1:0] dat_r;
    logic                      ack;

    modport master (
        output stb, we, adr, dat_w,
        input  dat_r, ack
    );

    // peripherals answer with data and a one-cycle ack
    modport slave (
        input  stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

//--- source/soc_pkg.sv
package soc_pkg;

    // decoder transaction phases
    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_access  = 2'd1,
        st_respond = 2'd2
    } bus_state_e;

    // target of the current access
    typedef enum logic [2:0] {
        sel_ram   = 3'd0,
        sel_timer = 3'd1,
        sel_prng  = 3'd2,
        sel_led   = 3'd3,
        sel_none  = 3'd4
    } periph_sel_e;

endpackage

//--- source/soc_settings.svh
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// bus widths
`define SOC_ADDR_BITS 16
`define SOC_DATA_BITS 8

// 1 KiB at 0x0000
`define RAM_ADDR_BITS 10

// peripheral pages, 256 bytes each
`define TIMER_BASE 16'hFD00
`define PRNG_BASE 16'hFE00
`define LED_BASE 16'hFF00

// returned for reads outside the map
`define UNMAPPED_DATA 8'hFF

// cycles of internal reset after rst_i is released
`define RESET_HOLD_CYCLES 16

`endif
